//--- include/vproc_defines.svh
`ifndef VPROC_DEFINES_SVH
`define VPROC_DEFINES_SVH

// Bus widths
`define VP_ADDR_W       32
`define VP_DATA_W       32
`define VP_OP_W         3
`define VP_CMD_W        (`VP_OP_W + `VP_ADDR_W + `VP_DATA_W)

// Sizes of the command store, request queue and slave memory
`define VP_CMD_DEPTH    16
`define VP_PC_W         4
`define VP_QUEUE_DEPTH  4
`define VP_MEM_WORDS    16

// Handler n starts at VP_IRQ_BASE + 2*(n-1)
`define VP_IRQ_BASE     10

// Command word is opcode, then address, then data
`define VP_CMD_OP_HI    66
`define VP_CMD_OP_LO    64
`define VP_CMD_ADDR_HI  63
`define VP_CMD_ADDR_LO  32
`define VP_CMD_DATA_HI  31
`define VP_CMD_DATA_LO  0

`endif

//--- verilog/vprocPkg.sv
`include "vproc_defines.svh"

package vprocPkg;

    // Bus address and data words; a wait command uses dataT as its tick count
    typedef logic [`VP_ADDR_W-1:0] addrT;
    typedef logic [`VP_DATA_W-1:0] dataT;

    // Index into the command store
    typedef logic [`VP_PC_W-1:0] pcT;

    // Full command word
    typedef logic [`VP_CMD_W-1:0] cmdT;

    typedef enum logic [`VP_OP_W-1:0] {
        opWrite  = 3'd0,
        opRead   = 3'd1,
        opWait   = 3'd2,
        opReturn = 3'd3,
        opHalt   = 3'd4
    } opT;

    // Sequencer states
    typedef enum logic [2:0] {
        msFetch,
        msDecode,
        msWait,
        msReqHi,
        msReqLo,
        msRspWait,
        msReport,
        msHalt
    } masterStateT;

    // Four-phase link states shared by the queue output and the slave response
    typedef enum logic [1:0] {
        lkIdle,
        lkReq,
        lkDrop
    } linkStateT;

endpackage

//--- verilog/cmdStore.sv
`include "vproc_defines.svh"

module cmdStore (
    input  logic           Clk,
    input  logic           rstN,
    input  logic           progWe,
    input  vprocPkg::pcT   progAddr,
    input  vprocPkg::cmdT  progCmd,
    input  vprocPkg::pcT   pc,
    output vprocPkg::cmdT  cmd
);

    // An empty slot holds a halt so a runaway PC stops the master
    localparam vprocPkg::cmdT HaltCmd = {vprocPkg::opHalt, {(`VP_ADDR_W + `VP_DATA_W){1'b0}}};

    vprocPkg::cmdT mem [`VP_CMD_DEPTH];

    always_ff @(posedge Clk)
    begin
        if (!rstN)
        begin
            for (int i = 0; i < `VP_CMD_DEPTH; i++)
            begin
                mem[i] <= HaltCmd;
            end
            cmd <= HaltCmd;
        end
        else
        begin
            if (progWe)
            begin
                mem[progAddr] <= progCmd;
            end
            // The read is registered so the command is ready one cycle after fetch
            cmd <= mem[pc];
        end
    end

endmodule

//--- verilog/busMaster.sv
`include "vproc_defines.svh"

module busMaster (
    input  logic            Clk,
    input  logic            rstN,
    input  logic            run,
    input  logic [2:0]      irq,
    input  vprocPkg::cmdT   cmd,
    input  logic            mAck,
    input  logic            rspReq,
    input  vprocPkg::dataT  rspData,
    output vprocPkg::pcT    pc,
    output logic            mReq,
    output logic            mReqWe,
    output vprocPkg::addrT  mReqAddr,
    output vprocPkg::dataT  mReqData,
    output logic            rspAck,
    output logic            update,
    output logic            updWe,
    output vprocPkg::addrT  updAddr,
    output vprocPkg::dataT  updData,
    output logic            halted
);

    vprocPkg::masterStateT state;
    vprocPkg::opT          op;
    vprocPkg::addrT        cmdAddr;
    vprocPkg::dataT        cmdData;
    vprocPkg::dataT        tickCnt;
    vprocPkg::dataT        rdData;
    vprocPkg::pcT          savedPc;
    logic                  inHandler;

    assign op      = vprocPkg::opT'(cmd[`VP_CMD_OP_HI:`VP_CMD_OP_LO]);
    assign cmdAddr = cmd[`VP_CMD_ADDR_HI:`VP_CMD_ADDR_LO];
    assign cmdData = cmd[`VP_CMD_DATA_HI:`VP_CMD_DATA_LO];

    always_ff @(posedge Clk)
    begin
        if (!rstN)
        begin
            state     <= vprocPkg::msFetch;
            pc        <= '0;
            savedPc   <= '0;
            inHandler <= 1'b0;
            tickCnt   <= '0;
            mReq      <= 1'b0;
            rspAck    <= 1'b0;
            update    <= 1'b0;
            halted    <= 1'b0;
        end
        else
        begin
            case (state)
                vprocPkg::msFetch:
                    if (run)
                    begin
                        // Interrupts only between commands and never nested
                        if (irq != 3'd0 && !inHandler)
                        begin
                            savedPc   <= pc;
                            inHandler <= 1'b1;
                            pc        <= vprocPkg::pcT'(`VP_IRQ_BASE + 2 * (irq - 3'd1));
                        end
                        else
                        begin
                            state <= vprocPkg::msDecode;
                        end
                    end
                vprocPkg::msDecode:
                    case (op)
                        vprocPkg::opWrite, vprocPkg::opRead:
                        begin
                            mReq  <= 1'b1;
                            state <= vprocPkg::msReqHi;
                        end
                        vprocPkg::opWait:
                            if (cmdData == '0)
                            begin
                                pc    <= pc + 1'b1;
                                state <= vprocPkg::msFetch;
                            end
                            else
                            begin
                                tickCnt <= cmdData;
                                state   <= vprocPkg::msWait;
                            end
                        vprocPkg::opReturn:
                        begin
                            pc        <= inHandler ? savedPc : pc + 1'b1;
                            inHandler <= 1'b0;
                            state     <= vprocPkg::msFetch;
                        end
                        default:
                        begin
                            halted <= 1'b1;
                            state  <= vprocPkg::msHalt;
                        end
                    endcase
                vprocPkg::msWait:
                    if (tickCnt == 1)
                    begin
                        pc    <= pc + 1'b1;
                        state <= vprocPkg::msFetch;
                    end
                    else
                    begin
                        tickCnt <= tickCnt - 1'b1;
                    end
                vprocPkg::msReqHi:
                    if (mAck)
                    begin
                        mReq  <= 1'b0;
                        state <= vprocPkg::msReqLo;
                    end
                vprocPkg::msReqLo:
                    // A posted write is done here, a read still needs its data
                    if (!mAck)
                    begin
                        state <= mReqWe ? vprocPkg::msReport : vprocPkg::msRspWait;
                    end
                vprocPkg::msRspWait:
                    if (rspReq && !rspAck)
                    begin
                        rspAck <= 1'b1;
                    end
                    else if (!rspReq && rspAck)
                    begin
                        rspAck <= 1'b0;
                        state  <= vprocPkg::msReport;
                    end
                vprocPkg::msReport:
                begin
                    update <= ~update;
                    pc     <= pc + 1'b1;
                    state  <= vprocPkg::msFetch;
                end
                default:
                    halted <= 1'b1;
            endcase
        end
    end

    // Request fields, read data and completion report
    always_ff @(posedge Clk)
    begin
        if (state == vprocPkg::msDecode &&
            (op == vprocPkg::opWrite || op == vprocPkg::opRead))
        begin
            mReqAddr <= cmdAddr;
            mReqData <= cmdData;
            mReqWe   <= (op == vprocPkg::opWrite);
        end
        if (state == vprocPkg::msRspWait && rspReq && !rspAck)
        begin
            rdData <= rspData;
        end
        if (state == vprocPkg::msReport)
        begin
            updAddr <= mReqAddr;
            updWe   <= mReqWe;
            updData <= mReqWe ? mReqData : rdData;
        end
    end

    // Request is withdrawn only once the queue has taken it
    reqHeldUntilAck: assert property (@(posedge Clk) disable iff (!rstN)
        $fell(mReq) |-> $past(mAck));

    reqFieldsStable: assert property (@(posedge Clk) disable iff (!rstN)
        mReq && $past(mReq) |-> $stable({mReqAddr, mReqData, mReqWe}));

endmodule

//--- verilog/reqQueue.sv
`include "vproc_defines.svh"

module reqQueue (
    input  logic            Clk,
    input  logic            rstN,
    input  logic            mReq,
    input  logic            mReqWe,
    input  vprocPkg::addrT  mReqAddr,
    input  vprocPkg::dataT  mReqData,
    input  logic            sAck,
    output logic            mAck,
    output logic            sReq,
    output logic            sReqWe,
    output vprocPkg::addrT  sReqAddr,
    output vprocPkg::dataT  sReqData
);

    localparam int PtrW = $clog2(`VP_QUEUE_DEPTH);
    localparam logic [PtrW:0] Full = `VP_QUEUE_DEPTH;

    vprocPkg::addrT      addrMem [`VP_QUEUE_DEPTH];
    vprocPkg::dataT      dataMem [`VP_QUEUE_DEPTH];
    logic                weMem   [`VP_QUEUE_DEPTH];
    logic [PtrW-1:0]     wrPtr;
    logic [PtrW-1:0]     rdPtr;
    logic [PtrW:0]       count;
    vprocPkg::linkStateT outState;
    logic                push;
    logic                pop;

    // Store on the rising ack; a full queue holds ack low
    assign push = mReq && !mAck && (count != Full);
    // Entry leaves once the slave drops its ack
    assign pop  = (outState == vprocPkg::lkDrop) && !sAck;

    always_ff @(posedge Clk)
    begin
        if (!rstN)
        begin
            mAck <= 1'b0;
        end
        else if (push)
        begin
            mAck <= 1'b1;
        end
        else if (mAck && !mReq)
        begin
            mAck <= 1'b0;
        end
    end

    always_ff @(posedge Clk)
    begin
        if (push)
        begin
            addrMem[wrPtr] <= mReqAddr;
            dataMem[wrPtr] <= mReqData;
            weMem[wrPtr]   <= mReqWe;
        end
    end

    always_ff @(posedge Clk)
    begin
        if (!rstN)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end
        else
        begin
            if (push)
            begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop)
            begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Output side offers the oldest entry
    always_ff @(posedge Clk)
    begin
        if (!rstN)
        begin
            outState <= vprocPkg::lkIdle;
            sReq     <= 1'b0;
        end
        else
        begin
            case (outState)
                vprocPkg::lkIdle:
                    if (count != '0)
                    begin
                        sReq     <= 1'b1;
                        outState <= vprocPkg::lkReq;
                    end
                vprocPkg::lkReq:
                    if (sAck)
                    begin
                        sReq     <= 1'b0;
                        outState <= vprocPkg::lkDrop;
                    end
                vprocPkg::lkDrop:
                    if (!sAck)
                    begin
                        outState <= vprocPkg::lkIdle;
                    end
                default:
                    outState <= vprocPkg::lkIdle;
            endcase
        end
    end

    assign sReqAddr = addrMem[rdPtr];
    assign sReqData = dataMem[rdPtr];
    assign sReqWe   = weMem[rdPtr];

    countInRange: assert property (@(posedge Clk) disable iff (!rstN)
        count <= Full);

endmodule

//--- verilog/memSlave.sv
`include "vproc_defines.svh"

module memSlave (
    input  logic            Clk,
    input  logic            rstN,
    input  logic            sReq,
    input  logic            sReqWe,
    input  vprocPkg::addrT  sReqAddr,
    input  vprocPkg::dataT  sReqData,
    input  logic            rspAck,
    output logic            sAck,
    output logic            rspReq,
    output vprocPkg::dataT  rspData
);

    localparam int IdxW = $clog2(`VP_MEM_WORDS);

    vprocPkg::dataT      mem [`VP_MEM_WORDS];
    logic [IdxW-1:0]     idx;
    vprocPkg::linkStateT rspState;
    logic                slowNext;
    logic                waited;
    logic                accept;

    assign idx = sReqAddr[IdxW-1:0];

    // Every other request waits one cycle; a read also needs a free response link
    assign accept = sReq && !sAck && (rspState == vprocPkg::lkIdle) && (!slowNext || waited);

    always_ff @(posedge Clk)
    begin
        if (!rstN)
        begin
            sAck     <= 1'b0;
            slowNext <= 1'b0;
            waited   <= 1'b0;
        end
        else if (accept)
        begin
            sAck     <= 1'b1;
            waited   <= 1'b0;
            slowNext <= ~slowNext;
        end
        else if (sReq && !sAck && slowNext)
        begin
            waited <= 1'b1;
        end
        else if (sAck && !sReq)
        begin
            sAck <= 1'b0;
        end
    end

    always_ff @(posedge Clk)
    begin
        if (!rstN)
        begin
            for (int i = 0; i < `VP_MEM_WORDS; i++)
            begin
                mem[i] <= '0;
            end
        end
        else if (accept && sReqWe)
        begin
            mem[idx] <= sReqData;
        end
    end

    // Read data goes back on its own channel
    always_ff @(posedge Clk)
    begin
        if (!rstN)
        begin
            rspState <= vprocPkg::lkIdle;
            rspReq   <= 1'b0;
        end
        else
        begin
            case (rspState)
                vprocPkg::lkIdle:
                    if (accept && !sReqWe)
                    begin
                        rspReq   <= 1'b1;
                        rspState <= vprocPkg::lkReq;
                    end
                vprocPkg::lkReq:
                    if (rspAck)
                    begin
                        rspReq   <= 1'b0;
                        rspState <= vprocPkg::lkDrop;
                    end
                vprocPkg::lkDrop:
                    if (!rspAck)
                    begin
                        rspState <= vprocPkg::lkIdle;
                    end
                default:
                    rspState <= vprocPkg::lkIdle;
            endcase
        end
    end

    always_ff @(posedge Clk)
    begin
        if (accept && !sReqWe)
        begin
            rspData <= mem[idx];
        end
    end

    // A response always answers a read taken from the queue
    rspAfterRead: assert property (@(posedge Clk) disable iff (!rstN)
        $rose(rspReq) |-> $past(sReq && !sReqWe));

endmodule

//--- verilog/busSubsystem.sv
module busSubsystem (
    input  logic            Clk,
    input  logic            rstN,
    input  logic            run,
    input  logic [2:0]      irq,
    input  logic            progWe,
    input  vprocPkg::pcT    progAddr,
    input  vprocPkg::cmdT   progCmd,
    output logic            update,
    output logic            updWe,
    output vprocPkg::addrT  updAddr,
    output vprocPkg::dataT  updData,
    output logic            halted
);

    // Command fetch
    vprocPkg::pcT   pc;
    vprocPkg::cmdT  cmd;

    // Master to queue
    logic           mReq;
    logic           mAck;
    logic           mReqWe;
    vprocPkg::addrT mReqAddr;
    vprocPkg::dataT mReqData;

    // Queue to slave
    logic           sReq;
    logic           sAck;
    logic           sReqWe;
    vprocPkg::addrT sReqAddr;
    vprocPkg::dataT sReqData;

    // Read response
    logic           rspReq;
    logic           rspAck;
    vprocPkg::dataT rspData;

    cmdStore cmdStore_i (
        .Clk      (Clk),
        .rstN     (rstN),
        .progWe   (progWe),
        .progAddr (progAddr),
        .progCmd  (progCmd),
        .pc       (pc),
        .cmd      (cmd)
    );

    busMaster busMaster_i (
        .Clk      (Clk),
        .rstN     (rstN),
        .run      (run),
        .irq      (irq),
        .cmd      (cmd),
        .mAck     (mAck),
        .rspReq   (rspReq),
        .rspData  (rspData),
        .pc       (pc),
        .mReq     (mReq),
        .mReqWe   (mReqWe),
        .mReqAddr (mReqAddr),
        .mReqData (mReqData),
        .rspAck   (rspAck),
        .update   (update),
        .updWe    (updWe),
        .updAddr  (updAddr),
        .updData  (updData),
        .halted   (halted)
    );

    reqQueue reqQueue_i (
        .Clk      (Clk),
        .rstN     (rstN),
        .mReq     (mReq),
        .mReqWe   (mReqWe),
        .mReqAddr (mReqAddr),
        .mReqData (mReqData),
        .sAck     (sAck),
        .mAck     (mAck),
        .sReq     (sReq),
        .sReqWe   (sReqWe),
        .sReqAddr (sReqAddr),
        .sReqData (sReqData)
    );

    memSlave memSlave_i (
        .Clk      (Clk),
        .rstN     (rstN),
        .sReq     (sReq),
        .sReqWe   (sReqWe),
        .sReqAddr (sReqAddr),
        .sReqData (sReqData),
        .rspAck   (rspAck),
        .sAck     (sAck),
        .rspReq   (rspReq),
        .rspData  (rspData)
    );

endmodule

//--- verif/clkGen.sv
module clkGen (
    output logic Clk,
    output logic rstN
);

    localparam int HalfPeriod = 10;
    localparam int ResetCycles = 4;

    initial
    begin
        Clk  = 1'b0;
        rstN = 1'b0;
        repeat (ResetCycles) @(posedge Clk);
        rstN <= 1'b1;
    end

    always #HalfPeriod Clk = ~Clk;

endmodule

//--- verif/busSubsystemTb.sv
`include "vproc_defines.svh"

module busSubsystemTb;

    localparam int UpdW        = 1 + `VP_ADDR_W + `VP_DATA_W;
    localparam int UpdTimeout  = 400;
    localparam int HaltTimeout = 400;
    localparam int QuietCycles = 20;

    logic           Clk;
    logic           genRstN;
    logic           tbRstN;
    logic           rstN;
    logic           run;
    logic [2:0]     irq;
    logic           progWe;
    vprocPkg::pcT   progAddr;
    vprocPkg::cmdT  progCmd;
    logic           update;
    logic           updWe;
    vprocPkg::addrT updAddr;
    vprocPkg::dataT updData;
    logic           halted;

    // Mirror of the command store and the expected updates {we, addr, data}
    vprocPkg::cmdT  prog [`VP_CMD_DEPTH];
    logic [UpdW-1:0] expQ [$];
    logic           lastUpd;
    int             testsRun;
    int             testsFailed;

    assign rstN = genRstN && tbRstN;

    clkGen clkGen_i (
        .Clk  (Clk),
        .rstN (genRstN)
    );

    busSubsystem dut_i (
        .Clk      (Clk),
        .rstN     (rstN),
        .run      (run),
        .irq      (irq),
        .progWe   (progWe),
        .progAddr (progAddr),
        .progCmd  (progCmd),
        .update   (update),
        .updWe    (updWe),
        .updAddr  (updAddr),
        .updData  (updData),
        .halted   (halted)
    );

    function automatic vprocPkg::cmdT makeCmd(input vprocPkg::opT op,
                                              input vprocPkg::addrT addr,
                                              input vprocPkg::dataT data);
        vprocPkg::cmdT c;
        c = '0;
        c[`VP_CMD_OP_HI:`VP_CMD_OP_LO]     = op;
        c[`VP_CMD_ADDR_HI:`VP_CMD_ADDR_LO] = addr;
        c[`VP_CMD_DATA_HI:`VP_CMD_DATA_LO] = data;
        return c;
    endfunction

    task automatic resetDut();
        @(posedge Clk);
        tbRstN <= 1'b0;
        run    <= 1'b0;
        irq    <= 3'd0;
        progWe <= 1'b0;
        repeat (4) @(posedge Clk);
        tbRstN <= 1'b1;
        lastUpd = 1'b0;
        // Store comes out of reset full of halts
        for (int i = 0; i < `VP_CMD_DEPTH; i++)
        begin
            prog[i] = makeCmd(vprocPkg::opHalt, '0, '0);
        end
    endtask

    task automatic loadSlot(input int slot, input vprocPkg::cmdT c);
        prog[slot] = c;
        @(posedge Clk);
        progWe   <= 1'b1;
        progAddr <= vprocPkg::pcT'(slot);
        progCmd  <= c;
    endtask

    // Reference model that runs the program and may take one interrupt at irqPc
    task automatic buildExpected(input int irqLevel, input int irqPc);
        vprocPkg::dataT modelMem [`VP_MEM_WORDS];
        vprocPkg::opT   op;
        vprocPkg::addrT addr;
        vprocPkg::dataT data;
        int             pc;
        int             savedPc;
        int             steps;
        bit             inHandler;
        bit             taken;
        bit             done;
        expQ.delete();
        for (int i = 0; i < `VP_MEM_WORDS; i++)
        begin
            modelMem[i] = '0;
        end
        pc        = 0;
        savedPc   = 0;
        steps     = 0;
        inHandler = 1'b0;
        taken     = 1'b0;
        done      = 1'b0;
        while (!done && steps < 100)
        begin
            steps++;
            if (irqLevel != 0 && !taken && !inHandler && pc == irqPc)
            begin
                savedPc   = pc;
                inHandler = 1'b1;
                taken     = 1'b1;
                pc        = `VP_IRQ_BASE + 2 * (irqLevel - 1);
            end
            else
            begin
                op   = vprocPkg::opT'(prog[pc][`VP_CMD_OP_HI:`VP_CMD_OP_LO]);
                addr = prog[pc][`VP_CMD_ADDR_HI:`VP_CMD_ADDR_LO];
                data = prog[pc][`VP_CMD_DATA_HI:`VP_CMD_DATA_LO];
                case (op)
                    vprocPkg::opWrite:
                    begin
                        modelMem[addr % `VP_MEM_WORDS] = data;
                        expQ.push_back({1'b1, addr, data});
                        pc = (pc + 1) % `VP_CMD_DEPTH;
                    end
                    vprocPkg::opRead:
                    begin
                        expQ.push_back({1'b0, addr, modelMem[addr % `VP_MEM_WORDS]});
                        pc = (pc + 1) % `VP_CMD_DEPTH;
                    end
                    vprocPkg::opWait:
                        pc = (pc + 1) % `VP_CMD_DEPTH;
                    vprocPkg::opReturn:
                    begin
                        pc        = inHandler ? savedPc : (pc + 1) % `VP_CMD_DEPTH;
                        inHandler = 1'b0;
                    end
                    default:
                        done = 1'b1;
                endcase
            end
        end
    endtask

    task automatic waitUpdate(output bit ok);
        int cycles;
        cycles = 0;
        ok     = 1'b0;
        while (!ok && cycles < UpdTimeout)
        begin
            @(negedge Clk);
            cycles++;
            if (update != lastUpd)
            begin
                ok      = 1'b1;
                lastUpd = update;
            end
        end
    endtask

    // Runs the loaded program; irq is raised after raiseAfter updates when irqLevel is set
    task automatic runProgram(input string name, input int irqLevel, input int raiseAfter);
        logic [UpdW-1:0] exp;
        logic [UpdW-1:0] act;
        bit              ok;
        bit              failed;
        int              cycles;
        failed = 1'b0;
        testsRun++;
        @(posedge Clk);
        progWe <= 1'b0;
        run    <= 1'b1;
        for (int i = 0; i < expQ.size() && !failed; i++)
        begin
            waitUpdate(ok);
            exp = expQ[i];
            act = {updWe, updAddr, updData};
            if (!ok)
            begin
                $display("%s: update %0d did not arrive within %0d cycles",
                         name, i, UpdTimeout);
                failed = 1'b1;
            end
            else if (act !== exp)
            begin
                $write("Error %s update %0d: expected we=%0b addr=%h data=%h",
                       name, i, exp[UpdW-1], exp[UpdW-2:`VP_DATA_W], exp[`VP_DATA_W-1:0]);
                $display(", actual we=%0b addr=%h data=%h", updWe, updAddr, updData);
                failed = 1'b1;
            end
            else if (irqLevel != 0 && i == raiseAfter - 1)
            begin
                @(posedge Clk);
                irq <= irqLevel[2:0];
            end
            else if (irqLevel != 0 && i == raiseAfter)
            begin
                // First handler update seen
                @(posedge Clk);
                irq <= 3'd0;
            end
        end
        ok     = 1'b0;
        cycles = 0;
        while (!failed && !ok && cycles < HaltTimeout)
        begin
            @(negedge Clk);
            cycles++;
            if (update != lastUpd)
            begin
                $display("%s: an update came after the last expected one", name);
                failed = 1'b1;
            end
            else if (halted)
            begin
                ok = 1'b1;
            end
        end
        if (!failed && !ok)
        begin
            $display("%s: master did not halt within %0d cycles", name, HaltTimeout);
            failed = 1'b1;
        end
        for (int i = 0; i < QuietCycles && !failed; i++)
        begin
            @(negedge Clk);
            if (update != lastUpd || !halted)
            begin
                $display("%s: master left the halted state or updated after halting", name);
                failed = 1'b1;
            end
        end
        if (failed)
        begin
            testsFailed++;
        end
        else
        begin
            $display("%s: passed with %0d updates", name, expQ.size());
        end
    endtask

    task automatic writeThenRead();
        resetDut();
        for (int i = 0; i < 4; i++)
        begin
            loadSlot(i, makeCmd(vprocPkg::opWrite, 32'h1000 + i, $urandom));
        end
        for (int i = 0; i < 4; i++)
        begin
            loadSlot(4 + i, makeCmd(vprocPkg::opRead, 32'h1000 + i, '0));
        end
        buildExpected(0, 0);
        runProgram("writeRead", 0, 0);
    endtask

    task automatic randomProgram(input int iter);
        int             len;
        vprocPkg::addrT addr;
        resetDut();
        len = $urandom_range(4, 9);
        for (int i = 0; i < len; i++)
        begin
            // Few distinct words so reads often hit earlier writes
            addr = ($urandom & 32'hffff_ff00) | $urandom_range(0, 3);
            case ($urandom_range(0, 2))
                0: loadSlot(i, makeCmd(vprocPkg::opWrite, addr, $urandom));
                1: loadSlot(i, makeCmd(vprocPkg::opRead, addr, $urandom));
                default: loadSlot(i, makeCmd(vprocPkg::opWait, addr, $urandom_range(0, 4)));
            endcase
        end
        loadSlot(len, makeCmd(vprocPkg::opHalt, '0, '0));
        buildExpected(0, 0);
        runProgram($sformatf("random%0d", iter), 0, 0);
    endtask

    task automatic backToBackWrites();
        resetDut();
        loadSlot(0, makeCmd(vprocPkg::opWrite, 32'h5, $urandom));
        loadSlot(1, makeCmd(vprocPkg::opWrite, 32'h6, $urandom));
        loadSlot(2, makeCmd(vprocPkg::opWrite, 32'h15, $urandom));
        loadSlot(3, makeCmd(vprocPkg::opWrite, 32'h7, $urandom));
        loadSlot(4, makeCmd(vprocPkg::opWrite, 32'h25, $urandom));
        loadSlot(5, makeCmd(vprocPkg::opWrite, 32'h8, $urandom));
        loadSlot(6, makeCmd(vprocPkg::opRead, 32'h5, '0));
        loadSlot(7, makeCmd(vprocPkg::opRead, 32'h7, '0));
        buildExpected(0, 0);
        runProgram("queueFill", 0, 0);
    endtask

    task automatic interruptDuringWait(input int level);
        resetDut();
        loadSlot(0, makeCmd(vprocPkg::opWrite, 32'h30, $urandom));
        loadSlot(1, makeCmd(vprocPkg::opWrite, 32'h31, $urandom));
        // Long wait so the raised irq is seen at the fetch of slot 3
        loadSlot(2, makeCmd(vprocPkg::opWait, '0, 32'd20));
        loadSlot(3, makeCmd(vprocPkg::opWrite, 32'h32, $urandom));
        loadSlot(4, makeCmd(vprocPkg::opRead, 32'h300 + level, '0));
        for (int h = 1; h <= 3; h++)
        begin
            loadSlot(`VP_IRQ_BASE + 2 * (h - 1),
                     makeCmd(vprocPkg::opWrite, 32'h100 + h, $urandom));
            loadSlot(`VP_IRQ_BASE + 2 * (h - 1) + 1, makeCmd(vprocPkg::opReturn, '0, '0));
        end
        buildExpected(level, 3);
        runProgram($sformatf("interrupt%0d", level), level, 2);
    endtask

    task automatic haltOnEmptySlot();
        resetDut();
        for (int i = 0; i < 3; i++)
        begin
            loadSlot(i, makeCmd(vprocPkg::opWrite, 32'h40 + i, $urandom));
        end
        buildExpected(0, 0);
        runProgram("unprogrammedHalt", 0, 0);
    endtask

    initial
    begin
        int cycles;
        void'($urandom(32'hd930_a2e1));
        tbRstN      = 1'b1;
        run         = 1'b0;
        irq         = 3'd0;
        progWe      = 1'b0;
        progAddr    = '0;
        progCmd     = '0;
        lastUpd     = 1'b0;
        testsRun    = 0;
        testsFailed = 0;
        cycles      = 0;
        while (genRstN !== 1'b1 && cycles < 20)
        begin
            @(posedge Clk);
            cycles++;
        end
        if (genRstN !== 1'b1)
        begin
            $display("Power-on reset from the clock generator never released");
            testsFailed++;
        end
        writeThenRead();
        for (int i = 0; i < 6; i++)
        begin
            randomProgram(i);
        end
        backToBackWrites();
        for (int n = 1; n <= 3; n++)
        begin
            interruptDuringWait(n);
        end
        haltOnEmptySlot();
        $display("Tests run %0d, passed %0d, failed %0d", testsRun, testsRun - testsFailed,
                 testsFailed);
        if (testsFailed == 0)
        begin
            $display("TESTS PASSED");
        end
        else
        begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- busSubsystem.f
+incdir+include
verilog/vprocPkg.sv
verilog/cmdStore.sv
verilog/busMaster.sv
verilog/reqQueue.sv
verilog/memSlave.sv
verilog/busSubsystem.sv
verif/clkGen.sv
verif/busSubsystemTb.sv
